/* hw/mpu_pkg.sv */
package mpu_pkg;

  // Datapath widths
  localparam int WORD_W    = 64;
  localparam int INSTR_W   = 48;
  localparam int REG_IDX_W = 5;
  localparam int IMM_W     = 16;
  localparam int OPC_W     = 4;
  localparam int NUM_REGS  = 1 << REG_IDX_W;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [INSTR_W-1:0]   instr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [IMM_W-1:0]     imm_t;

  // Instruction field positions
  localparam int OPC_HI = 47;
  localparam int OPC_LO = 44;
  localparam int RD_HI  = 43;
  localparam int RD_LO  = 39;
  localparam int RA_HI  = 38;
  localparam int RA_LO  = 34;
  localparam int RB_HI  = 33;
  localparam int RB_LO  = 29;
  localparam int IMM_HI = 15;
  localparam int IMM_LO = 0;

  // Encodings above OP_END are illegal
  typedef enum logic [OPC_W-1:0] {
    OP_NOP = 4'd0,
    OP_LDI = 4'd1,
    OP_ADD = 4'd2,
    OP_SUB = 4'd3,
    OP_XOR = 4'd4,
    OP_LDM = 4'd5,
    OP_JNZ = 4'd6,
    OP_IRQ = 4'd7,
    OP_END = 4'd8
  } opcode_t;

  typedef enum logic [1:0] {
    S_FETCH,
    S_EXEC,
    S_MEM,
    S_HALT
  } seq_state_t;

endpackage

/* hw/mpu_if.sv */
`timescale 1ns/1ps

// Decoded instruction, decoder to execution
interface mpu_op_if;
  import mpu_pkg::*;

  opcode_t  opcode;
  reg_idx_t rd;
  word_t    value_a;
  word_t    value_b;
  // Already sign-extended
  word_t    imm;
  logic     illegal;

  modport source (output opcode, rd, value_a, value_b, imm, illegal);
  modport sink   (input  opcode, rd, value_a, value_b, imm, illegal);
endinterface

// Two register read ports
interface mpu_rd_if;
  import mpu_pkg::*;

  reg_idx_t idx_a;
  reg_idx_t idx_b;
  word_t    data_a;
  word_t    data_b;

  modport requester (output idx_a, idx_b, input  data_a, data_b);
  modport responder (input  idx_a, idx_b, output data_a, data_b);
endinterface

/* hw/mpu_counter.sv */
`timescale 1ns/1ps

module mpu_counter #(
  parameter int IADDR_W = 16
) (
  input  logic               sys_clk,
  input  logic               rst_n,
  input  logic               en,
  input  logic               ip_step,
  input  logic               ip_load,
  input  logic [IADDR_W-1:0] ip_data,
  output logic [IADDR_W-1:0] addr
);

  // Instruction pointer, load wins over step
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (en) begin
      if (ip_load) begin
        addr <= ip_data;
      end else if (ip_step) begin
        addr <= addr + 1'b1;
      end
    end
  end

  // Sequencer issues exactly one kind of IP update per instruction
  a_step_load_excl: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    !(ip_step && ip_load)
  );

endmodule

/* hw/mpu_decoder.sv */
`timescale 1ns/1ps

module mpu_decoder (
  input  mpu_pkg::instr_t i_data,
  mpu_rd_if.requester     rd,
  mpu_op_if.source        op
);
  import mpu_pkg::*;

  logic [OPC_W-1:0] opc_raw;
  reg_idx_t         rd_field;
  reg_idx_t         ra_field;
  reg_idx_t         rb_field;
  imm_t             imm_field;

  // Field extraction
  assign opc_raw   = i_data[OPC_HI:OPC_LO];
  assign rd_field  = i_data[RD_HI:RD_LO];
  assign ra_field  = i_data[RA_HI:RA_LO];
  assign rb_field  = i_data[RB_HI:RB_LO];
  assign imm_field = i_data[IMM_HI:IMM_LO];

  // Operand requests to the register file
  assign rd.idx_a = ra_field;
  assign rd.idx_b = rb_field;

  assign op.opcode  = opcode_t'(opc_raw);
  assign op.rd      = rd_field;
  assign op.value_a = rd.data_a;
  assign op.value_b = rd.data_b;

  // Sign extend to full word
  assign op.imm = {{(WORD_W-IMM_W){imm_field[IMM_W-1]}}, imm_field};

  // Everything past OP_END is undefined
  assign op.illegal = (opc_raw > OP_END);

endmodule

/* hw/mpu_execution.sv */
`timescale 1ns/1ps

module mpu_execution #(
  parameter int IADDR_W = 16
) (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  logic                 en,
  mpu_op_if.sink               op,
  input  mpu_pkg::word_t       hm_data,
  output logic                 ip_step,
  output logic                 ip_load,
  output logic [IADDR_W-1:0]   ip_data,
  output logic                 we,
  output mpu_pkg::reg_idx_t    w_idx,
  output mpu_pkg::word_t       w_data,
  output mpu_pkg::word_t       hm_addr,
  output logic                 hm_start,
  output logic                 user_irq,
  output mpu_pkg::word_t       user_data,
  output logic                 user_end,
  output logic                 error
);
  import mpu_pkg::*;

  seq_state_t state_q;
  seq_state_t state_d;
  word_t      alu_res;
  logic       irq_d;
  logic       end_d;
  logic       err_d;

  // ALU
  always_comb begin
    case (op.opcode)
      OP_ADD:  alu_res = op.value_a + op.value_b;
      OP_SUB:  alu_res = op.value_a - op.value_b;
      OP_XOR:  alu_res = op.value_a ^ op.value_b;
      default: alu_res = op.imm;
    endcase
  end

  // Host address is ra + imm
  assign hm_addr = op.value_a + op.imm;
  assign ip_data = op.imm[IADDR_W-1:0];
  assign w_idx   = op.rd;

  // Sequencer next state and per-cycle controls
  always_comb begin
    state_d  = state_q;
    ip_step  = 1'b0;
    ip_load  = 1'b0;
    we       = 1'b0;
    w_data   = alu_res;
    hm_start = 1'b0;
    irq_d    = 1'b0;
    end_d    = 1'b0;
    err_d    = 1'b0;
    case (state_q)
      S_FETCH: begin
        state_d = S_EXEC;
      end
      S_EXEC: begin
        state_d = S_FETCH;
        if (op.illegal) begin
          err_d   = 1'b1;
          state_d = S_HALT;
        end else begin
          case (op.opcode)
            OP_NOP: ip_step = 1'b1;
            OP_LDI, OP_ADD, OP_SUB, OP_XOR: begin
              we      = 1'b1;
              ip_step = 1'b1;
            end
            OP_LDM: begin
              // Single request, even across a stall
              hm_start = en;
              state_d  = S_MEM;
            end
            OP_JNZ: begin
              if (op.value_a != '0) begin
                ip_load = 1'b1;
              end else begin
                ip_step = 1'b1;
              end
            end
            OP_IRQ: begin
              irq_d   = 1'b1;
              ip_step = 1'b1;
            end
            OP_END: begin
              end_d   = 1'b1;
              state_d = S_HALT;
            end
            default: begin
              err_d   = 1'b1;
              state_d = S_HALT;
            end
          endcase
        end
      end
      S_MEM: begin
        // Host word arrives one cycle after the request
        we      = 1'b1;
        w_data  = hm_data;
        ip_step = 1'b1;
        state_d = S_FETCH;
      end
      default: state_d = S_HALT;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      state_q  <= S_FETCH;
      user_irq <= 1'b0;
      user_end <= 1'b0;
      error    <= 1'b0;
    end else begin
      // Pulse lasts one cycle even when en drops right after
      user_irq <= en && irq_d;
      if (en) begin
        state_q <= state_d;
        if (end_d) begin
          user_end <= 1'b1;
        end
        if (err_d) begin
          error <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (en && irq_d) begin
      user_data <= op.value_a;
    end
  end

  a_hm_single: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    hm_start |=> !hm_start
  );

  a_we_idle: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (state_q == S_FETCH || state_q == S_HALT) |-> !we
  );

endmodule

/* hw/mpu_registers.sv */
`timescale 1ns/1ps

module mpu_registers (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic              we,
  input  mpu_pkg::reg_idx_t w_idx,
  input  mpu_pkg::word_t    w_data,
  mpu_rd_if.responder       rd
);
  import mpu_pkg::*;

  word_t regs [NUM_REGS];

  // Register 0 is hardwired to zero
  assign rd.data_a = (rd.idx_a == '0) ? '0 : regs[rd.idx_a];
  assign rd.data_b = (rd.idx_b == '0) ? '0 : regs[rd.idx_b];

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (en && we && (w_idx != '0)) begin
      regs[w_idx] <= w_data;
    end
  end

  // Write index comes straight from the fetched instruction
  a_widx_known: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (en && we) |-> !$isunknown(w_idx)
  );

endmodule

/* hw/mpu_top.sv */
`timescale 1ns/1ps

module mpu_top #(
  parameter int IADDR_W = 16
) (
  // System
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  logic                 en,

  // Instruction memory, synchronous
  output logic [IADDR_W-1:0]   i_addr,
  input  mpu_pkg::instr_t      i_data,

  // User interrupts
  output logic                 user_irq,
  output mpu_pkg::word_t       user_data,
  output logic                 user_end,

  // Host memory under check, answers one cycle after hm_start
  output mpu_pkg::word_t       hm_addr,
  output logic                 hm_start,
  input  mpu_pkg::word_t       hm_data,

  output logic                 error
);
  import mpu_pkg::*;

  logic               ip_step;
  logic               ip_load;
  logic [IADDR_W-1:0] ip_data;

  // Write-back path
  logic     we;
  reg_idx_t w_idx;
  word_t    w_data;

  mpu_op_if op_bus ();
  mpu_rd_if rd_bus ();

  mpu_counter #(
    .IADDR_W (IADDR_W)
  ) ip (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .en      (en),
    .ip_step (ip_step),
    .ip_load (ip_load),
    .ip_data (ip_data),
    .addr    (i_addr)
  );

  mpu_decoder decoder (
    .i_data (i_data),
    .rd     (rd_bus.requester),
    .op     (op_bus.source)
  );

  mpu_execution #(
    .IADDR_W (IADDR_W)
  ) execution (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .en        (en),
    .op        (op_bus.sink),
    .hm_data   (hm_data),
    .ip_step   (ip_step),
    .ip_load   (ip_load),
    .ip_data   (ip_data),
    .we        (we),
    .w_idx     (w_idx),
    .w_data    (w_data),
    .hm_addr   (hm_addr),
    .hm_start  (hm_start),
    .user_irq  (user_irq),
    .user_data (user_data),
    .user_end  (user_end),
    .error     (error)
  );

  mpu_registers registers (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .en      (en),
    .we      (we),
    .w_idx   (w_idx),
    .w_data  (w_data),
    .rd      (rd_bus.responder)
  );

endmodule

/* verification/mpu_tb.sv */
`timescale 1ns/1ps

module mpu_tb;
  import mpu_pkg::*;

  localparam int      NUM_TESTS  = 6;
  localparam int      PROG_LEN   = 8;
  localparam int      RST_CYCLES = 5;
  localparam realtime CLK_NS     = 100;
  // Every row gets 8 instructions at 3 cycles each, plus its reset
  localparam realtime WATCHDOG_NS =
    (NUM_TESTS * PROG_LEN * 3 + NUM_TESTS * RST_CYCLES) * CLK_NS;
  localparam word_t   HOST_MASK  = 64'h5a5a_0000_0000_0000;

  logic        sys_clk = 1'b0;
  logic        rst_n   = 1'b0;
  logic        en      = 1'b0;
  instr_t      i_data  = '0;
  word_t       hm_data = '0;
  logic [15:0] i_addr;
  logic        user_irq;
  logic        user_end;
  logic        hm_start;
  logic        error;
  word_t       user_data;
  word_t       hm_addr;

  instr_t imem [PROG_LEN];
  string  names [NUM_TESTS];
  instr_t progs [NUM_TESTS][PROG_LEN];
  word_t  exp_irq [NUM_TESTS][$];
  word_t  exp_hm [NUM_TESTS][$];
  logic   exp_end [NUM_TESTS];
  logic   exp_err [NUM_TESTS];
  logic   stalls [NUM_TESTS];
  word_t  irq_seen [$];
  word_t  hm_seen [$];
  logic   running = 1'b0;
  integer seed    = 32'h17eb_cac0;

  mpu_top #(.IADDR_W(16)) mpu_top_i (.*);

  initial begin
    forever #(CLK_NS / 2) sys_clk = ~sys_clk;
  end

  // Instruction memory with one cycle of latency
  // Past the program it returns illegal words
  always @(posedge sys_clk) begin
    i_data <= (i_addr < PROG_LEN) ? imem[i_addr[2:0]] : {4'hf, 28'h0, i_addr};
  end

  // Host memory answers the cycle after hm_start
  always @(posedge sys_clk) begin
    if (hm_start) hm_data <= hm_addr ^ HOST_MASK;
  end

  // Sampled mid-cycle where the outputs are settled
  always @(negedge sys_clk) begin
    if (running && user_irq) irq_seen.push_back(user_data);
    if (running && hm_start) hm_seen.push_back(hm_addr);
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, the DUT never reached end or error", $time);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  function automatic instr_t encode(logic [OPC_W-1:0] opc, reg_idx_t rd, reg_idx_t ra,
                                    reg_idx_t rb, imm_t imm);
    return {opc, rd, ra, rb, 13'h0, imm};
  endfunction

  function automatic word_t sign_extend(imm_t v);
    return {{48{v[15]}}, v};
  endfunction

  task automatic compare_word(string what, word_t exp, word_t act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", what, exp, act);
      $display("Done: errors found");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic compare_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("FAILED %s: expected %b, actual %b", what, exp, act);
      $display("Done: errors found");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic build_table();
    word_t a;
    foreach (progs[r, i]) progs[r][i] = encode(OP_END, 5'd0, 5'd0, 5'd0, 16'h0);
    foreach (names[r]) begin
      exp_end[r] = 1'b1;
      exp_err[r] = 1'b0;
      stalls[r]  = 1'b0;
    end
    names[0] = "ldi_irq";
    progs[0][0] = encode(OP_LDI, 5'd1, 5'd0, 5'd0, 16'hfff0);
    progs[0][1] = encode(OP_IRQ, 5'd0, 5'd1, 5'd0, 16'h0);
    exp_irq[0].push_back(sign_extend(16'hfff0));
    // Wrap-around through the top of the 64-bit range
    names[1] = "alu_wrap";
    a = sign_extend(16'h8000);
    progs[1][0] = encode(OP_LDI, 5'd1, 5'd0, 5'd0, 16'h8000);
    progs[1][1] = encode(OP_ADD, 5'd2, 5'd1, 5'd1, 16'h0);
    progs[1][2] = encode(OP_SUB, 5'd3, 5'd0, 5'd1, 16'h0);
    progs[1][3] = encode(OP_XOR, 5'd4, 5'd2, 5'd3, 16'h0);
    progs[1][4] = encode(OP_IRQ, 5'd0, 5'd2, 5'd0, 16'h0);
    progs[1][5] = encode(OP_IRQ, 5'd0, 5'd3, 5'd0, 16'h0);
    progs[1][6] = encode(OP_IRQ, 5'd0, 5'd4, 5'd0, 16'h0);
    exp_irq[1].push_back(a + a);
    exp_irq[1].push_back(64'd0 - a);
    exp_irq[1].push_back((a + a) ^ (64'd0 - a));
    // Negative offset from the base register
    names[2] = "host_load";
    a = 64'h100 + sign_extend(16'hfff8);
    progs[2][0] = encode(OP_LDI, 5'd1, 5'd0, 5'd0, 16'h0100);
    progs[2][1] = encode(OP_LDM, 5'd2, 5'd1, 5'd0, 16'hfff8);
    progs[2][2] = encode(OP_IRQ, 5'd0, 5'd2, 5'd0, 16'h0);
    exp_hm[2].push_back(a);
    exp_irq[2].push_back(a ^ HOST_MASK);
    // Count r1 down to zero, then try to write r0
    names[3] = "jnz_loop";
    progs[3][0] = encode(OP_LDI, 5'd1, 5'd0, 5'd0, 16'd2);
    progs[3][1] = encode(OP_LDI, 5'd2, 5'd0, 5'd0, 16'd1);
    progs[3][2] = encode(OP_IRQ, 5'd0, 5'd1, 5'd0, 16'h0);
    progs[3][3] = encode(OP_SUB, 5'd1, 5'd1, 5'd2, 16'h0);
    progs[3][4] = encode(OP_JNZ, 5'd0, 5'd1, 5'd0, 16'd2);
    progs[3][5] = encode(OP_LDI, 5'd0, 5'd0, 5'd0, 16'h0055);
    progs[3][6] = encode(OP_IRQ, 5'd0, 5'd0, 5'd0, 16'h0);
    names[4] = "illegal_op";
    exp_end[4] = 1'b0;
    exp_err[4] = 1'b1;
    progs[4][0] = encode(OP_LDI, 5'd1, 5'd0, 5'd0, 16'd7);
    progs[4][1] = encode(OP_IRQ, 5'd0, 5'd1, 5'd0, 16'h0);
    progs[4][2] = encode(4'hb, 5'd0, 5'd0, 5'd0, 16'h0);
    progs[4][3] = encode(OP_IRQ, 5'd0, 5'd1, 5'd0, 16'h0);
    exp_irq[4].push_back(64'd7);
    names[5] = "jnz_stall";
    stalls[5] = 1'b1;
    for (int i = 0; i < PROG_LEN; i++) begin
      progs[5][i] = progs[3][i];
    end
    for (int v = 2; v >= 0; v--) begin
      exp_irq[3].push_back(word_t'(v));
      exp_irq[5].push_back(word_t'(v));
    end
  endtask

  task automatic run_test(int r);
    @(posedge sys_clk);
    #10;
    rst_n = 1'b0;
    en = 1'b1;
    foreach (imem[i]) imem[i] = progs[r][i];
    irq_seen.delete();
    hm_seen.delete();
    repeat (RST_CYCLES) @(posedge sys_clk);
    #10;
    rst_n = 1'b1;
    running = 1'b1;
    while (!(user_end || error)) begin
      @(posedge sys_clk);
      #10;
      if (stalls[r]) en = ($random(seed) & 7) != 0;
    end
    // A few more cycles to catch interrupts after the halt
    en = 1'b1;
    repeat (2) @(posedge sys_clk);
    #10;
    running = 1'b0;
    compare_flag({names[r], " end"}, exp_end[r], user_end);
    compare_flag({names[r], " error"}, exp_err[r], error);
    compare_word({names[r], " irq count"}, word_t'(exp_irq[r].size()),
                 word_t'(irq_seen.size()));
    for (int i = 0; i < exp_irq[r].size(); i++) begin
      compare_word($sformatf("%s irq %0d", names[r], i), exp_irq[r][i], irq_seen[i]);
    end
    compare_word({names[r], " hm_start count"}, word_t'(exp_hm[r].size()),
                 word_t'(hm_seen.size()));
    for (int i = 0; i < exp_hm[r].size(); i++) begin
      compare_word($sformatf("%s hm_addr %0d", names[r], i), exp_hm[r][i], hm_seen[i]);
    end
  endtask

  initial begin
    build_table();
    for (int r = 0; r < NUM_TESTS; r++) begin
      run_test(r);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

/* sim.f */
hw/mpu_pkg.sv
hw/mpu_if.sv
hw/mpu_counter.sv
hw/mpu_decoder.sv
hw/mpu_execution.sv
hw/mpu_registers.sv
hw/mpu_top.sv
verification/mpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the MPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mpu_tb \
  -f sim.f \
  -o mpu_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/mpu_sim
